// File: hdl/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    localparam int word_width = 16;                  // data and address width
    localparam int reg_count  = 8;                   // architectural registers
    localparam int pc_step    = 2;                   // byte-addressed words

    typedef logic [word_width-1:0] lc3b_word;
    typedef logic [2:0]            lc3b_reg;

    // lc3b encodings, only the supported subset
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // execute stage controls
    typedef struct packed {
        lc3b_aluop   aluop;
        logic        offset6_lsse;                   // shift offset6 left by one
        logic [1:0]  alumux_sel;                     // 00 sr2, 10 imm5, 11 adj6
        logic        mdrmux_ex_sel;                  // store data from sr2
    } lc3b_ex_ctrl;

    // memory stage controls
    typedef struct packed {
        logic        d_mem_read;
        logic        d_mem_write;
    } lc3b_mem_ctrl;

    // writeback stage controls
    typedef struct packed {
        lc3b_opcode  opcode;
        logic [1:0]  regfilemux_sel;                 // 00 alu, 01 load data
        logic        load_regfile;
        logic        load_cc;
    } lc3b_wb_ctrl;

    typedef struct packed {
        logic         src2mux_sel;                   // sr2 index from ir[11:9]
        lc3b_ex_ctrl  ex;
        lc3b_mem_ctrl mem;
        lc3b_wb_ctrl  wb;
    } lc3b_control_word;

endpackage : lc3b_pkg

`default_nettype wire

// File: hdl/cpu_control.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_control import lc3b_pkg::*; (
    input  lc3b_opcode       opcode,
    input  logic             ir_4,
    input  logic             ir_5,
    input  logic             ir_11,
    output lc3b_control_word cw
);

    always_comb begin : decode
        // all-zero word is a bubble
        cw = '0;
        cw.wb.opcode = opcode;

        case (opcode)
            op_add: begin
                cw.ex.aluop = alu_add;
                cw.wb.regfilemux_sel = 2'b00;        // alu result
                cw.wb.load_regfile = ir_5 | ~ir_4;   // ir[4] must be clear in register form
                cw.wb.load_cc = ir_5 | ~ir_4;
                if (ir_5) begin
                    cw.ex.alumux_sel = 2'b10;        // imm5
                end else begin
                    cw.ex.alumux_sel = 2'b00;        // sr2
                end
            end
            op_and: begin
                cw.ex.aluop = alu_and;
                cw.wb.regfilemux_sel = 2'b00;
                cw.wb.load_regfile = ir_5 | ~ir_4;
                cw.wb.load_cc = ir_5 | ~ir_4;
                if (ir_5) begin
                    cw.ex.alumux_sel = 2'b10;
                end else begin
                    cw.ex.alumux_sel = 2'b00;
                end
            end
            op_not: begin
                cw.ex.aluop = alu_not;
                cw.wb.regfilemux_sel = 2'b00;
                cw.wb.load_regfile = ir_5 & ir_4;    // low bits of a valid NOT are all ones
                cw.wb.load_cc = ir_5 & ir_4;
            end
            op_ldr: begin
                cw.ex.offset6_lsse = 1'b1;           // word offset
                cw.ex.alumux_sel = 2'b11;            // adj6
                cw.ex.aluop = alu_add;

                cw.mem.d_mem_read = 1'b1;

                cw.wb.regfilemux_sel = 2'b01;        // load data
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            op_str: begin
                cw.src2mux_sel = 1'b1;               // read the SR field as sr2

                cw.ex.offset6_lsse = 1'b1;
                cw.ex.alumux_sel = 2'b11;
                cw.ex.aluop = alu_add;
                cw.ex.mdrmux_ex_sel = 1'b1;          // sr2 is the store data

                cw.mem.d_mem_write = 1'b1;
            end
            op_br: begin
                // never taken here, runs as a no-op
            end
            default: begin
                cw.wb.opcode = op_br;                // unsupported opcode runs as a no-op
            end
        endcase
    end

endmodule : cpu_control

`default_nettype wire

// File: hdl/lc3b_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module lc3b_regfile import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  lc3b_reg  sr1,
    input  lc3b_reg  sr2,
    input  lc3b_reg  dest,
    input  lc3b_word wdata,
    input  logic     load,
    output lc3b_word sr1_out,
    output lc3b_word sr2_out
);

    lc3b_word regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= wdata;
        end
    end

    // read ports, no write bypass
    assign sr1_out = regs[sr1];
    assign sr2_out = regs[sr2];

endmodule : lc3b_regfile

`default_nettype wire

// File: hdl/lc3b_stage_reg.sv
`default_nettype none
`timescale 1ns/1ps

module lc3b_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;                                 // bubble
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule : lc3b_stage_reg

`default_nettype wire

// File: hdl/lc3b_mem_stage.sv
`default_nettype none
`timescale 1ns/1ps

module lc3b_mem_stage import lc3b_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  lc3b_mem_ctrl mem_ctrl,
    input  lc3b_word     addr,
    input  lc3b_word     store_data,
    output lc3b_word     load_data,
    output logic         stall,
    output logic         psel,
    output logic         penable,
    output logic         pwrite,
    output lc3b_word     paddr,
    output lc3b_word     pwdata,
    input  lc3b_word     prdata,
    input  logic         pready
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t state;
    state_t state_next;
    logic   mem_op;
    logic   done;

    assign mem_op = mem_ctrl.d_mem_read | mem_ctrl.d_mem_write;
    assign done   = (state == st_access) && pready;    // transfer completes this cycle

    always_comb begin
        state_next = state;
        case (state)
            st_idle:   if (mem_op) state_next = st_setup;
            st_setup:  state_next = st_access;
            st_access: if (pready) state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // address and data come straight from the held MEM register
    assign psel    = (state != st_idle);
    assign penable = (state == st_access);
    assign pwrite  = psel & mem_ctrl.d_mem_write;
    assign paddr   = addr;
    assign pwdata  = store_data;

    assign stall     = mem_op & ~done;                 // release on the pready cycle
    assign load_data = (done && mem_ctrl.d_mem_read) ? prdata : '0;

endmodule : lc3b_mem_stage

`default_nettype wire

// File: hdl/lc3b_pipe.sv
`default_nettype none
`timescale 1ns/1ps

module lc3b_pipe import lc3b_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output lc3b_word   imem_addr,
    input  lc3b_word   imem_rdata,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output lc3b_word   paddr,
    output lc3b_word   pwdata,
    input  lc3b_word   prdata,
    input  logic       pready,
    output logic [2:0] cc
);

    typedef struct packed {
        lc3b_word ir;
    } id_payload_t;

    typedef struct packed {
        lc3b_ex_ctrl  ex;
        lc3b_mem_ctrl mem;
        lc3b_wb_ctrl  wb;
        lc3b_word     sr1_val;
        lc3b_word     sr2_val;
        lc3b_reg      dest;
        logic [4:0]   imm5;
        logic [5:0]   offset6;
    } ex_payload_t;

    typedef struct packed {
        lc3b_mem_ctrl mem;
        lc3b_wb_ctrl  wb;
        lc3b_word     alu_out;
        lc3b_word     store_data;
        lc3b_reg      dest;
    } mem_payload_t;

    typedef struct packed {
        lc3b_wb_ctrl wb;
        lc3b_word    alu_out;
        lc3b_word    load_data;
        lc3b_reg     dest;
    } wb_payload_t;

    lc3b_word         pc;
    logic             stall;
    id_payload_t      id_d, id_q;
    ex_payload_t      ex_d, ex_q;
    mem_payload_t     mem_d, mem_q;
    wb_payload_t      wb_d, wb_q;
    lc3b_control_word cw;
    lc3b_reg          sr2_sel;
    lc3b_word         sr1_val, sr2_val;
    lc3b_word         imm5_sext, adj6, alu_b, alu_out;
    lc3b_word         load_data;
    lc3b_word         wb_data;

    // fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + lc3b_word'(pc_step);
        end
    end

    assign imem_addr = pc;
    assign id_d.ir   = imem_rdata;

    lc3b_stage_reg #(.payload_t(id_payload_t)) i_id_reg (
        .clk(clk), .reset(reset), .stall(stall), .d(id_d), .q(id_q)
    );

    // decode and register read
    cpu_control i_cpu_control (
        .opcode(lc3b_opcode'(id_q.ir[15:12])),
        .ir_4(id_q.ir[4]),
        .ir_5(id_q.ir[5]),
        .ir_11(id_q.ir[11]),
        .cw(cw)
    );

    assign sr2_sel = cw.src2mux_sel ? id_q.ir[11:9] : id_q.ir[2:0];

    lc3b_regfile i_regfile (
        .clk(clk), .reset(reset),
        .sr1(id_q.ir[8:6]), .sr2(sr2_sel), .dest(wb_q.dest),
        .wdata(wb_data), .load(wb_q.wb.load_regfile),
        .sr1_out(sr1_val), .sr2_out(sr2_val)
    );

    assign ex_d = '{ex: cw.ex, mem: cw.mem, wb: cw.wb, sr1_val: sr1_val, sr2_val: sr2_val,
                    dest: id_q.ir[11:9], imm5: id_q.ir[4:0], offset6: id_q.ir[5:0]};

    lc3b_stage_reg #(.payload_t(ex_payload_t)) i_ex_reg (
        .clk(clk), .reset(reset), .stall(stall), .d(ex_d), .q(ex_q)
    );

    // execute
    assign imm5_sext = {{(word_width-5){ex_q.imm5[4]}}, ex_q.imm5};
    assign adj6 = ex_q.ex.offset6_lsse ? {{(word_width-7){ex_q.offset6[5]}}, ex_q.offset6, 1'b0}
                                       : {{(word_width-6){ex_q.offset6[5]}}, ex_q.offset6};

    always_comb begin
        case (ex_q.ex.alumux_sel)
            2'b10:   alu_b = imm5_sext;
            2'b11:   alu_b = adj6;                   // base plus word offset
            default: alu_b = ex_q.sr2_val;
        endcase
        case (ex_q.ex.aluop)
            alu_add:  alu_out = ex_q.sr1_val + alu_b;
            alu_and:  alu_out = ex_q.sr1_val & alu_b;
            alu_not:  alu_out = ~ex_q.sr1_val;
            alu_pass: alu_out = ex_q.sr1_val;
            default:  alu_out = ex_q.sr1_val;
        endcase
    end

    assign mem_d = '{mem: ex_q.mem, wb: ex_q.wb, alu_out: alu_out,
                     store_data: ex_q.ex.mdrmux_ex_sel ? ex_q.sr2_val : '0, dest: ex_q.dest};

    lc3b_stage_reg #(.payload_t(mem_payload_t)) i_mem_reg (
        .clk(clk), .reset(reset), .stall(stall), .d(mem_d), .q(mem_q)
    );

    // memory
    lc3b_mem_stage i_mem_stage (
        .clk(clk), .reset(reset),
        .mem_ctrl(mem_q.mem), .addr(mem_q.alu_out), .store_data(mem_q.store_data),
        .load_data(load_data), .stall(stall),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready)
    );

    // a stalled memory stage sends a bubble down to writeback
    assign wb_d = stall ? '0 : '{wb: mem_q.wb, alu_out: mem_q.alu_out,
                                 load_data: load_data, dest: mem_q.dest};

    lc3b_stage_reg #(.payload_t(wb_payload_t)) i_wb_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .d(wb_d), .q(wb_q)
    );

    // writeback
    assign wb_data = (wb_q.wb.regfilemux_sel == 2'b01) ? wb_q.load_data : wb_q.alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            cc <= '0;
        end else if (wb_q.wb.load_cc) begin
            if (wb_data[word_width-1]) begin
                cc <= 3'b100;                        // n
            end else if (wb_data == '0) begin
                cc <= 3'b010;                        // z
            end else begin
                cc <= 3'b001;                        // p
            end
        end
    end

endmodule : lc3b_pipe

`default_nettype wire

// File: verif/lc3b_pipe_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module lc3b_pipe_assertions import lc3b_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  lc3b_word imem_addr,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  lc3b_word paddr,
    input  lc3b_word pwdata,
    input  logic     pready
);

    int fail_count = 0;                              // read by the testbench at the end

    // outputs frozen while the slave inserts wait states
    apb_hold: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else begin
            fail_count++;
            $error("apb outputs changed before pready");
        end

    apb_setup_then_access: assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |=> (psel && penable))
        else begin
            fail_count++;
            $error("apb setup cycle not followed by an access cycle");
        end

    apb_enable_needs_sel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel)
        else begin
            fail_count++;
            $error("penable high without psel");
        end

    pc_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(imem_addr))
        else begin
            fail_count++;
            $error("fetch address moved during a stall");
        end

    pc_advance: assert property (@(posedge clk) disable iff (reset)
        !stall |=> (imem_addr == $past(imem_addr) + lc3b_word'(pc_step)))
        else begin
            fail_count++;
            $error("fetch address did not advance by one instruction");
        end

endmodule : lc3b_pipe_assertions

`default_nettype wire

// File: verif/lc3b_pipe_tb.sv
`default_nettype none
`timescale 1ns/1ps

module lc3b_pipe_tb import lc3b_pkg::*; ();

    localparam logic [31:0] lfsr_seed   = 32'h57ec8b2a;
    localparam int          timeout_cyc = 2000;
    localparam lc3b_word    final_addr  = 16'h0000;  // last store lands on word 0

    logic       clk;
    logic       reset;
    lc3b_word   imem_addr;
    lc3b_word   imem_rdata;
    logic       psel;
    logic       penable;
    logic       pwrite;
    lc3b_word   paddr;
    lc3b_word   pwdata;
    lc3b_word   prdata = '0;
    logic       pready = 1'b0;
    logic [2:0] cc;

    lc3b_word    rom [64];
    lc3b_word    data_mem [64];
    lc3b_word    expected [8];
    logic [31:0] lfsr_state;
    logic [1:0]  wait_left;
    logic        final_store_seen;
    int          prog_len;
    int          check_count = 0;
    int          error_count = 0;
    int          cycles;
    logic        timed_out = 1'b0;

    lc3b_pipe i_lc3b_pipe (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .cc(cc)
    );

    bind lc3b_pipe lc3b_pipe_assertions i_pipe_assertions (
        .clk(clk), .reset(reset), .stall(stall), .imem_addr(imem_addr),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic lc3b_word fill_word(input logic [5:0] idx);
        return {idx, 4'ha, idx} ^ 16'h0f0f;          // every address bit shows up
    endfunction

    function automatic lc3b_word enc_rr(input logic [3:0] op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_word enc_ri(input logic [3:0] op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input logic [4:0] imm5);
        return {op, dr, sr1, 1'b1, imm5};
    endfunction

    function automatic lc3b_word enc_mem(input logic [3:0] op, input lc3b_reg r,
                                         input lc3b_reg base, input logic [5:0] off6);
        return {op, r, base, off6};
    endfunction

    task automatic emit(input lc3b_word instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic emit_nops(input int n);
        for (int i = 0; i < n; i++) begin
            emit(16'h0000);                          // BR with nzp 000
        end
    endtask

    task automatic check_value(input string name, input lc3b_word exp_val,
                               input lc3b_word act_val);
        check_count++;
        assert (act_val == exp_val) else begin
            error_count++;
            $display("** Error: %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    // single-cycle instruction port, no-ops past the image
    always_comb begin
        if (imem_addr[15:7] == '0) begin
            imem_rdata = rom[imem_addr[6:1]];
        end else begin
            imem_rdata = '0;
        end
    end

    // apb slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin : apb_slave
        logic [31:0] s1;
        logic [1:0]  waits;
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                data_mem[i] <= fill_word(6'(i));
            end
            lfsr_state <= lfsr_seed;
            pready <= 1'b0;
            prdata <= '0;
            wait_left <= '0;
            final_store_seen <= 1'b0;
        end else if (psel && !penable) begin
            s1 = lfsr_next(lfsr_state);
            waits = {s1[0], lfsr_state[0]};
            lfsr_state <= lfsr_next(s1);
            wait_left <= waits;
            if (waits == 2'd0) begin
                pready <= 1'b1;
                prdata <= data_mem[paddr[6:1]];
            end else begin
                pready <= 1'b0;
            end
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;
                if (pwrite) begin
                    data_mem[paddr[6:1]] <= pwdata;
                    if (paddr == final_addr) begin
                        final_store_seen <= 1'b1;
                    end
                end
            end else if (wait_left == 2'd1) begin
                pready <= 1'b1;
                prdata <= data_mem[paddr[6:1]];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else begin
            pready <= 1'b0;
        end
    end

    initial begin
        reset = 1'b1;
        prog_len = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        emit(enc_ri(op_add, 3'd1, 3'd0, 5'd7));      // r1 = 7
        emit(enc_ri(op_add, 3'd2, 3'd0, 5'b11101));  // r2 = -3
        emit(enc_mem(op_ldr, 3'd3, 3'd0, 6'd5));     // r3 = word 5
        emit_nops(4);
        emit(enc_rr(op_add, 3'd4, 3'd1, 3'd2));
        emit(enc_rr(op_and, 3'd5, 3'd3, 3'd1));
        emit(enc_ri(op_and, 3'd6, 3'd3, 5'b10000));  // mask -16
        emit({4'b1001, 3'd7, 3'd2, 6'b111111});      // not r7, r2
        emit_nops(4);
        emit(enc_ri(op_and, 3'd1, 3'd2, 5'b11000));  // last alu op, negative result
        emit_nops(4);
        for (int k = 0; k < 8; k++) begin
            emit(enc_mem(op_str, 3'(k), 3'd0, 6'(16 + k)));
        end
        emit(enc_mem(op_str, 3'd7, 3'd4, 6'b111110)); // r4 minus 4 bytes

        // register values worked out from the instruction semantics
        expected[0] = 16'h0000;
        expected[1] = 16'hfffd & 16'hfff8;
        expected[2] = 16'hfffd;
        expected[3] = fill_word(6'd5);
        expected[4] = 16'h0007 + 16'hfffd;
        expected[5] = fill_word(6'd5) & 16'h0007;
        expected[6] = fill_word(6'd5) & 16'hfff0;
        expected[7] = ~16'hfffd;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset psel", 16'(1'b0), 16'(psel));
        check_value("reset penable", 16'(1'b0), 16'(penable));
        check_value("reset pwrite", 16'(1'b0), 16'(pwrite));
        check_value("reset imem_addr", 16'h0000, imem_addr);

        cycles = 0;
        while (!final_store_seen && cycles < timeout_cyc) begin
            @(posedge clk);
            cycles++;
        end
        if (!final_store_seen) begin
            timed_out = 1'b1;
            $display("timeout: final store not seen after %0d cycles", cycles);
        end
        @(negedge clk);

        for (int k = 0; k < 8; k++) begin
            check_value($sformatf("store r%0d", k), expected[k], data_mem[16 + k]);
        end
        check_value("store r7 via r4 base", expected[7], data_mem[0]);
        check_value("cc after last alu op", 16'(3'b100), 16'(cc));

        $display("checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_count, error_count, i_lc3b_pipe.i_pipe_assertions.fail_count,
                 timed_out);
        if (error_count == 0 && i_lc3b_pipe.i_pipe_assertions.fail_count == 0
                && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : lc3b_pipe_tb

`default_nettype wire

// File: lc3b_pipe.f
hdl/lc3b_pkg.sv
hdl/cpu_control.sv
hdl/lc3b_regfile.sv
hdl/lc3b_stage_reg.sv
hdl/lc3b_mem_stage.sv
hdl/lc3b_pipe.sv
verif/lc3b_pipe_assertions.sv
verif/lc3b_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the lc3b pipeline testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module lc3b_pipe_tb -f lc3b_pipe.f -o lc3b_pipe_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/lc3b_pipe_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
